/* verilog/mapper_pkg.sv */
// shared types for the memory-mapper RAM subsystem
// the bus side follows the 8-bit expansion bus with single-cycle strobes
// the RAM side carries a 22-bit physical address, of which the RAM keeps
// only its low RAM_ADDR_BITS bits
// segment registers sit on four consecutive I/O ports from seg_port_base

package mapper_pkg;

	// ----------------------------------------
	// constants
	// ----------------------------------------

	// I/O port of the page 0 segment register, pages 1..3 follow it
	localparam logic [7:0] seg_port_base = 8'hFC;

	// 8-bit segment number joined to a 14-bit page offset
	localparam int phys_addr_bits = 22;

	// ----------------------------------------
	// bus side
	// ----------------------------------------

	// one strobe from the bus master
	// valid when exactly one of read/write and one of io/memory is high
	typedef struct packed {
		logic [15:0] address;
		logic [7:0]  write_data;
		logic        read;
		logic        write;
		logic        io;
		logic        memory;
	} bus_req_t;

	// read data is zero whenever read_ready is low
	typedef struct packed {
		logic       read_ready;
		logic [7:0] read_data;
	} bus_rsp_t;

	// ----------------------------------------
	// RAM side
	// ----------------------------------------

	typedef struct packed {
		logic                      rd;
		logic                      wr;
		logic [phys_addr_bits-1:0] address;
		logic [7:0]                wdata;
	} ram_req_t;

	// rdata is only meaningful while rdata_en is high
	typedef struct packed {
		logic       rdata_en;
		logic [7:0] rdata;
	} ram_rsp_t;

endpackage

/* verilog/ram_array.sv */
// synchronous byte RAM with a fixed read latency
// RAM_ADDR_BITS is 14..22, upper physical address bits are dropped so
// segments above the installed size alias onto lower ones
// READ_LATENCY is at least 1, reads may be issued every cycle and up to
// READ_LATENCY of them can be in flight
// contents are undefined after reset

`timescale 1ns/10ps

module ram_array
	import mapper_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 17,
	parameter int READ_LATENCY  = 2
) (
	input  logic     clk,
	input  logic     n_reset,
	input  ram_req_t ram_req,
	output ram_rsp_t ram_rsp
);

	localparam int ram_depth = 2 ** RAM_ADDR_BITS;

	// storage
	logic [7:0] mem [ram_depth];

	// low address bits only, this is where aliasing happens
	logic [RAM_ADDR_BITS-1:0] ram_index;

	// read pipeline, stage 0 is loaded at the strobe edge
	logic [READ_LATENCY-1:0] pipe_valid;
	logic [7:0]              pipe_data [READ_LATENCY];

	assign ram_index = ram_req.address[RAM_ADDR_BITS-1:0];

	// ----------------------------------------
	// write port
	// ----------------------------------------

	// stored at the edge that ends the strobe cycle
	always_ff @(posedge clk) begin
		if (ram_req.wr) begin
			mem[ram_index] <= ram_req.wdata;
		end
	end

	// ----------------------------------------
	// read pipeline, valid bits
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid[0] <= ram_req.rd;
			// shift towards the output stage
			for (int i = 1; i < READ_LATENCY; i++) begin
				pipe_valid[i] <= pipe_valid[i-1];
			end
		end
	end

	// ----------------------------------------
	// read pipeline, data
	// ----------------------------------------

	// array read happens in stage 0, later stages only delay it
	always_ff @(posedge clk) begin
		if (ram_req.rd) begin
			pipe_data[0] <= mem[ram_index];
		end
		for (int i = 1; i < READ_LATENCY; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	// ----------------------------------------
	// response
	// ----------------------------------------

	// last stage is the response, READ_LATENCY cycles after the strobe
	// data is not masked here, the mapper zeroes it when rdata_en is low
	always_comb begin
		ram_rsp.rdata_en = pipe_valid[READ_LATENCY-1];
		ram_rsp.rdata    = pipe_data[READ_LATENCY-1];
	end

endmodule

/* verilog/mapper_ram.sv */
// memory mapper: four segment registers on I/O ports FC..FF, one per 16 KB page
// RAM requests are combinational in the strobe cycle, nothing is registered
// I/O readback of the segment registers answers one cycle after the strobe
// a memory response and an I/O readback must not land in the same cycle,
// if they do the memory response wins and the readback is dropped
// I/O reads of any other port get no response at all

`timescale 1ns/10ps

module mapper_ram
	import mapper_pkg::*;
(
	input  logic     clk,
	input  logic     n_reset,
	input  bus_req_t bus_req,
	output bus_rsp_t bus_rsp,
	output ram_req_t ram_req,
	input  ram_rsp_t ram_rsp
);

	// strobe decode
	logic       strobe_ok;
	logic       io_write;
	logic       io_read;
	logic       mem_write;
	logic       mem_read;

	// port decode relative to the first segment port
	logic [7:0] port_offset;
	logic       port_hit;
	logic [1:0] port_sel;

	// one byte per page, index is the page number
	logic [3:0][7:0] seg_reg;
	logic [1:0]      page_sel;
	logic [7:0]      page_seg;

	// registered I/O readback
	logic       io_rsp_valid;
	logic [7:0] io_rsp_data;

	// ----------------------------------------
	// strobe decode
	// ----------------------------------------

	// exactly one direction and exactly one space, anything else is idle
	assign strobe_ok = (bus_req.read ^ bus_req.write) & (bus_req.io ^ bus_req.memory);

	assign io_write  = strobe_ok & bus_req.io & bus_req.write;
	assign io_read   = strobe_ok & bus_req.io & bus_req.read;
	assign mem_write = strobe_ok & bus_req.memory & bus_req.write;
	assign mem_read  = strobe_ok & bus_req.memory & bus_req.read;

	// only the low address byte selects an I/O port
	assign port_offset = bus_req.address[7:0] - seg_port_base;
	assign port_hit    = (port_offset[7:2] == 6'd0);
	assign port_sel    = port_offset[1:0];

	// ----------------------------------------
	// segment registers
	// ----------------------------------------

	// new value is visible to a memory strobe in the very next cycle
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			seg_reg <= '0;
		end else if (io_write && port_hit) begin
			seg_reg[port_sel] <= bus_req.write_data;
		end
	end

	// ----------------------------------------
	// page decode and RAM request
	// ----------------------------------------

	// cpu address bits 15..14 pick the page
	assign page_sel = bus_req.address[15:14];
	assign page_seg = seg_reg[page_sel];

	always_comb begin
		ram_req.rd      = mem_read;
		ram_req.wr      = mem_write;
		// segment on top, 14-bit page offset below
		ram_req.address = {page_seg, bus_req.address[13:0]};
		ram_req.wdata   = bus_req.write_data;
	end

	// ----------------------------------------
	// I/O readback
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			io_rsp_valid <= 1'b0;
		end else begin
			io_rsp_valid <= io_read & port_hit;
		end
	end

	// data only loads on a hit, it is masked by the valid bit downstream
	always_ff @(posedge clk) begin
		if (io_read && port_hit) begin
			io_rsp_data <= seg_reg[port_sel];
		end
	end

	// ----------------------------------------
	// response merge
	// ----------------------------------------

	// RAM data has priority, an idle bus carries zero data
	always_comb begin
		if (ram_rsp.rdata_en) begin
			bus_rsp.read_ready = 1'b1;
			bus_rsp.read_data  = ram_rsp.rdata;
		end else if (io_rsp_valid) begin
			bus_rsp.read_ready = 1'b1;
			bus_rsp.read_data  = io_rsp_data;
		end else begin
			bus_rsp.read_ready = 1'b0;
			bus_rsp.read_data  = 8'd0;
		end
	end

endmodule

/* verilog/mapper_subsystem.sv */
// memory-mapper RAM slot: segment registers on ports FC..FF plus a byte RAM
// RAM_ADDR_BITS sets the installed size (14..22), default 128 KB, 8 segments
// READ_LATENCY sets memory read latency in cycles, at least 1
// I/O readback always answers after one cycle
// the master must keep an I/O readback off any cycle that already carries
// a memory response, and gets no back-pressure of any kind

`timescale 1ns/10ps

module mapper_subsystem
	import mapper_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 17,
	parameter int READ_LATENCY  = 2
) (
	input  logic     clk,
	input  logic     n_reset,
	input  bus_req_t bus_req,
	output bus_rsp_t bus_rsp
);

	// ----------------------------------------
	// mapper to RAM
	// ----------------------------------------

	// request is combinational in the strobe cycle
	ram_req_t ram_req;
	// response comes back READ_LATENCY cycles later
	ram_rsp_t ram_rsp;

	// ----------------------------------------
	// mapper
	// ----------------------------------------

	// segment registers, page decode and the bus response merge
	mapper_ram mapper_ram_inst (
		.clk     (clk),
		.n_reset (n_reset),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp)
	);

	// ----------------------------------------
	// RAM
	// ----------------------------------------

	// size and latency come from the top level
	ram_array #(
		.RAM_ADDR_BITS (RAM_ADDR_BITS),
		.READ_LATENCY  (READ_LATENCY)
	) ram_array_inst (
		.clk     (clk),
		.n_reset (n_reset),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp)
	);

endmodule

/* verif/tb_tasks.svh */
// bus helpers for the mapper subsystem testbench, included inside its top module
// they use clk, bus_req, bus_rsp, test_errors and timeout_cycles of that module
// each strobe is driven at a falling edge and lasts exactly one cycle

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------
// compare tasks
// ----------------------------------------

task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s read_ready %h read_data %h expected %h %h",
			name, got.read_ready, got.read_data, exp.read_ready, exp.read_data);
		test_errors++;
	end
endtask

task automatic check_seg(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		test_errors++;
	end
endtask

// ----------------------------------------
// bus drive
// ----------------------------------------

// sets the request without waiting for an edge
task automatic set_bus(input logic [15:0] address, input logic [7:0] data,
		input logic rd, input logic wr, input logic io, input logic mem);
	bus_req.address    = address;
	bus_req.write_data = data;
	bus_req.read       = rd;
	bus_req.write      = wr;
	bus_req.io         = io;
	bus_req.memory     = mem;
endtask

task automatic drive_strobe(input logic [15:0] address, input logic [7:0] data,
		input logic rd, input logic wr, input logic io, input logic mem);
	@(negedge clk);
	set_bus(address, data, rd, wr, io, mem);
endtask

task automatic go_idle();
	@(negedge clk);
	bus_req = '0;
endtask

task automatic io_write(input logic [7:0] port, input logic [7:0] data);
	drive_strobe({8'h00, port}, data, 1'b0, 1'b1, 1'b1, 1'b0);
	go_idle();
endtask

task automatic mem_write(input logic [15:0] address, input logic [7:0] data);
	drive_strobe(address, data, 1'b0, 1'b1, 1'b0, 1'b1);
	go_idle();
endtask

// ----------------------------------------
// response wait
// ----------------------------------------

// call right after a read strobe, cycles counts falling edges since it
// idle cycles must carry zero read data
task automatic wait_response(output bus_rsp_t rsp, output int cycles, output bit got);
	got    = 1'b0;
	cycles = 0;
	rsp    = '0;
	while (!got && cycles < timeout_cycles) begin
		@(negedge clk);
		cycles++;
		// strobe lasts one cycle only
		if (cycles == 1) begin
			bus_req = '0;
		end
		if (bus_rsp.read_ready === 1'b1) begin
			got = 1'b1;
			rsp = bus_rsp;
		end else begin
			check_rsp("bus_rsp while idle", bus_rsp, '0);
		end
	end
endtask

`endif

/* verif/tb_mapper_subsystem.sv */
// directed testbench for the memory-mapper RAM subsystem
// inputs change on the falling edge, outputs are sampled there too
// the model only predicts bytes that were written earlier in the run
// a watchdog ends the run if the whole sequence stalls

`timescale 1ns/10ps

module tb_mapper_subsystem
	import mapper_pkg::*;
();

	localparam int RAM_ADDR_BITS   = 17;
	localparam int READ_LATENCY    = 2;
	localparam int ram_depth       = 2 ** RAM_ADDR_BITS;
	localparam int timeout_cycles  = 16;
	localparam int watchdog_cycles = 20000;

	logic     clk;
	logic     n_reset;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// bookkeeping
	int test_errors;
	int error_count;
	int tests_run;
	int tests_failed;
	int unsigned seed_value;

	// reference model of the RAM bytes and the four segment registers
	logic [7:0] model_mem [ram_depth];
	logic [7:0] model_seg [4];

	`include "tb_tasks.svh"

	mapper_subsystem #(
		.RAM_ADDR_BITS (RAM_ADDR_BITS),
		.READ_LATENCY  (READ_LATENCY)
	) mapper_subsystem_inst (
		.clk     (clk),
		.n_reset (n_reset),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		for (int i = 0; i < watchdog_cycles; i++) begin
			@(posedge clk);
		end
		$display("simulation ran past %0d cycles without finishing", watchdog_cycles);
		$display("Test FAILED");
		$finish;
	end

	// ----------------------------------------
	// model helpers
	// ----------------------------------------

	// segment times page size plus offset, wrapped to the installed size
	function automatic int model_index(input logic [7:0] seg, input logic [13:0] offset);
		return (int'(seg) * 16384 + int'(offset)) % ram_depth;
	endfunction

	function automatic logic [7:0] model_byte(input logic [1:0] page, input logic [13:0] offset);
		return model_mem[model_index(model_seg[page], offset)];
	endfunction

	task automatic set_segment(input logic [1:0] page, input logic [7:0] seg);
		io_write(seg_port_base + {6'd0, page}, seg);
		model_seg[page] = seg;
	endtask

	task automatic write_byte(input logic [1:0] page, input logic [13:0] offset,
			input logic [7:0] data);
		mem_write({page, offset}, data);
		model_mem[model_index(model_seg[page], offset)] = data;
	endtask

	task automatic read_and_check_byte(input logic [1:0] page, input logic [13:0] offset,
			input logic [7:0] expected);
		bus_rsp_t rsp;
		bus_rsp_t exp;
		int cycles;
		bit got;
		drive_strobe({page, offset}, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
		wait_response(rsp, cycles, got);
		exp.read_ready = 1'b1;
		exp.read_data  = expected;
		if (!got) begin
			$display("memory read of page %0d offset %h got no read_ready", page, offset);
			test_errors++;
		end else begin
			if (cycles != READ_LATENCY) begin
				$display("memory read answered after %0d cycles instead of %0d",
					cycles, READ_LATENCY);
				test_errors++;
			end
			check_rsp("bus_rsp memory read", rsp, exp);
		end
	endtask

	task automatic read_and_check_seg(input logic [1:0] page);
		bus_rsp_t rsp;
		int cycles;
		bit got;
		drive_strobe({8'h00, seg_port_base + {6'd0, page}}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
		wait_response(rsp, cycles, got);
		if (!got) begin
			$display("segment readback of page %0d got no read_ready", page);
			test_errors++;
		end else begin
			if (cycles != 1) begin
				$display("segment readback answered after %0d cycles instead of 1", cycles);
				test_errors++;
			end
			check_seg($sformatf("bus_rsp.read_data segment page %0d", page),
				rsp.read_data, model_seg[page]);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		error_count += test_errors;
		test_errors = 0;
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_reset_readback();
		for (int p = 0; p < 4; p++) begin
			read_and_check_seg(2'(p));
		end
		finish_test("reset readback");
	endtask

	task automatic test_segment_ports();
		bus_rsp_t rsp;
		int cycles;
		bit got;
		for (int p = 0; p < 4; p++) begin
			set_segment(2'(p), 8'($urandom));
		end
		for (int p = 0; p < 4; p++) begin
			read_and_check_seg(2'(p));
		end
		// a port outside FC..FF must leave the segment registers alone
		io_write(8'h3F, 8'($urandom));
		for (int p = 0; p < 4; p++) begin
			read_and_check_seg(2'(p));
		end
		drive_strobe(16'h003F, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
		wait_response(rsp, cycles, got);
		if (got) begin
			$display("port 3F read returned read_ready after %0d cycles", cycles);
			test_errors++;
		end else begin
			$display("port 3F read got no read_ready within %0d cycles", timeout_cycles);
		end
		finish_test("segment ports");
	endtask

	task automatic test_random_memory();
		logic [13:0] offsets [8];
		for (int p = 0; p < 4; p++) begin
			set_segment(2'(p), 8'($urandom));
			for (int i = 0; i < 8; i++) begin
				offsets[i] = 14'($urandom);
				write_byte(2'(p), offsets[i], 8'($urandom));
			end
			for (int i = 0; i < 8; i++) begin
				read_and_check_byte(2'(p), offsets[i], model_byte(2'(p), offsets[i]));
			end
		end
		finish_test("random memory");
	endtask

	task automatic test_aliasing();
		logic [7:0]  seg;
		logic [7:0]  seg_high;
		logic [13:0] offset;
		logic [7:0]  data;
		seg    = 8'($urandom);
		offset = 14'($urandom);
		data   = 8'($urandom);
		// same segment in two pages
		set_segment(2'd1, seg);
		set_segment(2'd2, seg);
		write_byte(2'd1, offset, data);
		read_and_check_byte(2'd2, offset, data);
		// flip the lowest segment bit that the RAM does not keep
		if (RAM_ADDR_BITS < phys_addr_bits) begin
			seg_high = seg ^ (8'h01 << (RAM_ADDR_BITS - 14));
			set_segment(2'd3, seg_high);
			read_and_check_byte(2'd3, offset, data);
			write_byte(2'd3, offset ^ 14'h0001, ~data);
			read_and_check_byte(2'd1, offset ^ 14'h0001, ~data);
		end
		finish_test("aliasing");
	endtask

	task automatic test_back_to_back();
		logic [13:0] base;
		logic [7:0]  data [4];
		bus_rsp_t    exp;
		int          k;
		base = 14'($urandom) & 14'h3FF0;
		set_segment(2'd0, 8'($urandom));
		for (int i = 0; i < 4; i++) begin
			data[i] = 8'($urandom);
			write_byte(2'd0, base + 14'(i), data[i]);
		end
		// four reads on consecutive edges give one response per cycle in order
		for (int c = 0; c < 4 + READ_LATENCY + 2; c++) begin
			@(negedge clk);
			k = c - READ_LATENCY;
			if (k >= 0 && k < 4) begin
				exp.read_ready = 1'b1;
				exp.read_data  = data[k];
			end else begin
				exp = '0;
			end
			check_rsp($sformatf("bus_rsp back-to-back cycle %0d", c), bus_rsp, exp);
			if (c < 4) begin
				set_bus({2'b00, base + 14'(c)}, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
			end else begin
				bus_req = '0;
			end
		end
		finish_test("back-to-back reads");
	endtask

	task automatic test_remap();
		logic [7:0]  seg_a;
		logic [7:0]  seg_b;
		logic [13:0] offset;
		logic [7:0]  data;
		seg_a  = 8'($urandom);
		seg_b  = seg_a ^ 8'h01;
		offset = 14'($urandom);
		data   = 8'($urandom);
		set_segment(2'd2, seg_a);
		write_byte(2'd2, offset, data);
		set_segment(2'd2, seg_b);
		write_byte(2'd2, offset, ~data);
		set_segment(2'd2, seg_a);
		read_and_check_byte(2'd2, offset, data);
		set_segment(2'd2, seg_b);
		read_and_check_byte(2'd2, offset, ~data);
		// restoring the first segment brings its byte back
		set_segment(2'd2, seg_a);
		read_and_check_byte(2'd2, offset, data);
		finish_test("remapping");
	endtask

	// ----------------------------------------
	// sequence
	// ----------------------------------------

	initial begin
		seed_value   = $urandom(32'h7269c451);
		test_errors  = 0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		bus_req      = '0;
		n_reset      = 1'b0;
		for (int p = 0; p < 4; p++) begin
			model_seg[p] = 8'h00;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b1;

		test_reset_readback();
		test_segment_ports();
		test_random_memory();
		test_aliasing();
		test_back_to_back();
		test_remap();

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+verif
verilog/mapper_pkg.sv
verilog/ram_array.sv
verilog/mapper_ram.sv
verilog/mapper_subsystem.sv
verif/tb_mapper_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the mapper subsystem testbench with Verilator and runs it
# the result is taken from the simulation log, not from the exit status alone

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir
sim_bin=sim_mapper

rm -f "$log_file"

# compile and elaborate, package first as given in the file list
verilator --binary --timing -f list.f \
	--top-module tb_mapper_subsystem \
	--Mdir "$obj_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# run the simulation and keep its output
"./$obj_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# only the pass line on its own counts as a pass
if grep -qx "Test OK" "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $log_file"
	exit 1
fi
